//--- build.f
design/memoryGamePkg.sv
design/playDecoder.sv
design/gameDatapath.sv
design/gameControl.sv
design/memoryGameTop.sv
test/memoryGameTb.sv

//--- design/gameControl.sv
// Memory game control unit
`timescale 1ns/1ns

module gameControl import memoryGamePkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  statusT    status,
    input  logic      playMade,
    output controlT   control,
    output logic      playerTurn,
    output logic      won,
    output logic      lost,
    output logic      timeout,
    output logic      ready,
    output gameStateT stateDebug
);

    gameStateT state;
    gameStateT nextState;
    logic      timeLimit;
    logic      lastRound;

    // Limits picked by the stored levels
    assign timeLimit = status.levelTime ? status.timerEnd : status.timerHalf;
    assign lastRound = status.levelPlays ? status.roundEnd : status.roundHalf;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (start) begin
                    nextState = setup;
                end
            end
            setup:      nextState = roundStart;
            roundStart: nextState = showLoad;
            showLoad:   nextState = showWait;
            showWait: begin
                if (status.displayEnd) begin
                    nextState = showNext;
                end
            end
            // Whole prefix shown once address reaches the round
            showNext: begin
                nextState = status.addressIsRound ? playStart : showLoad;
            end
            playStart:  nextState = playWait;
            playWait: begin
                if (timeLimit) begin
                    nextState = timedOut;
                end else if (playMade) begin
                    nextState = capture;
                end
            end
            capture:    nextState = compare;
            compare: begin
                if (!status.playCorrect) begin
                    nextState = gameLost;
                end else if (!status.addressIsRound) begin
                    nextState = nextPlay;
                end else if (lastRound) begin
                    nextState = gameWon;
                end else begin
                    nextState = nextRound;
                end
            end
            nextPlay:   nextState = playWait;
            nextRound:  nextState = roundStart;
            // End states wait for a new game
            gameWon, gameLost, timedOut: begin
                if (start) begin
                    nextState = setup;
                end
            end
            default:    nextState = idle;
        endcase
    end

    // ------------------------------
    // Moore outputs
    // ------------------------------
    always_comb begin
        control = '0;
        case (state)
            setup: begin
                control.clearRound = 1'b1;
                control.clearTimer = 1'b1;
                control.clearPlay  = 1'b1;
                control.storeLevel = 1'b1;
            end
            roundStart: control.clearAddress = 1'b1;
            showLoad:   control.clearDisplay = 1'b1;
            showWait: begin
                control.countDisplay = 1'b1;
                control.ledsOn       = 1'b1;
            end
            showNext:   control.countAddress = 1'b1;
            playStart: begin
                control.clearAddress = 1'b1;
                control.clearTimer   = 1'b1;
            end
            playWait:   control.countTimer = 1'b1;
            capture:    control.storePlay = 1'b1;
            nextPlay: begin
                control.countAddress = 1'b1;
                control.clearTimer   = 1'b1;
            end
            nextRound:  control.countRound = 1'b1;
            default:    control = '0;
        endcase
    end

    assign playerTurn = (state == playWait);
    assign won        = (state == gameWon);
    assign lost       = (state == gameLost);
    assign timeout    = (state == timedOut);
    assign ready      = won || lost || timeout;
    assign stateDebug = state;

    // ------------------------------
    // Checks
    // ------------------------------
    outcomeOneHot : assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({won, lost, timeout})
    );

    // Address never runs past the round counter
    addressWithinRound : assert property (
        @(posedge clock) disable iff (reset)
        (state == compare && status.addressEnd) |-> status.addressIsRound
    );

endmodule

//--- design/gameDatapath.sv
// Memory game datapath
`timescale 1ns/1ns

module gameDatapath import memoryGamePkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  controlT control,
    input  logic    playMade,
    input  colorT   playColor,
    input  logic    levelTime,
    input  logic    levelPlays,
    output statusT  status,
    output colorT   leds
);

    addressT address;
    addressT round;
    tickT    displayCount;
    timerT   timer;
    colorT   playRegister;
    logic    levelTimeReg;
    logic    levelPlaysReg;
    colorT   expectedColor;

    // ------------------------------
    // Counters
    // ------------------------------

    // Position in the sequence, shared by show and play
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            address <= '0;
        end else if (control.clearAddress) begin
            address <= '0;
        end else if (control.countAddress) begin
            address <= address + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            round <= '0;
        end else if (control.clearRound) begin
            round <= '0;
        end else if (control.countRound) begin
            round <= round + 1'b1;
        end
    end

    // Cycles the current colour has been lit
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            displayCount <= '0;
        end else if (control.clearDisplay) begin
            displayCount <= '0;
        end else if (control.countDisplay) begin
            displayCount <= displayCount + 1'b1;
        end
    end

    // Play timer, restarted for every expected press
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            timer <= '0;
        end else if (control.clearTimer) begin
            timer <= '0;
        end else if (control.countTimer) begin
            timer <= timer + 1'b1;
        end
    end

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clock) begin
        if (control.clearPlay) begin
            playRegister <= '0;
        end else if (control.storePlay) begin
            playRegister <= playColor;
        end
    end

    // Levels sampled once per game
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            levelTimeReg  <= 1'b0;
            levelPlaysReg <= 1'b0;
        end else if (control.storeLevel) begin
            levelTimeReg  <= levelTime;
            levelPlaysReg <= levelPlays;
        end
    end

    // ------------------------------
    // Lookup and status
    // ------------------------------
    assign expectedColor = colorSequence[address];

    assign status.addressEnd     = (address == lastAddress);
    assign status.displayEnd     = (displayCount == displayLast);
    assign status.roundEnd       = (round == lastLongRound);
    assign status.roundHalf      = (round == lastShortRound);
    assign status.timerEnd       = (timer == timerFullLimit);
    assign status.timerHalf      = (timer == timerHalfLimit);
    assign status.addressIsRound = (address == round);
    assign status.playCorrect    = (playRegister == expectedColor);
    assign status.levelTime      = levelTimeReg;
    assign status.levelPlays     = levelPlaysReg;

    // LEDs dark outside the show phase
    assign leds = control.ledsOn ? expectedColor : '0;

    // ------------------------------
    // Checks
    // ------------------------------
    timerStrobes : assert property (
        @(posedge clock) disable iff (reset)
        !(control.countTimer && control.clearTimer)
    );

    // The play register is only loaded right after a press strobe
    storeAfterPress : assert property (
        @(posedge clock) disable iff (reset)
        control.storePlay |-> $past(playMade)
    );

endmodule

//--- design/memoryGamePkg.sv
// Memory game shared definitions
package memoryGamePkg;

    // ------------------------------
    // Widths
    // ------------------------------
    typedef logic [3:0] colorT;
    typedef logic [3:0] addressT;
    typedef logic [5:0] timerT;
    typedef logic [2:0] tickT;

    // ------------------------------
    // Game constants
    // ------------------------------
    localparam int sequenceLength = 16;
    localparam int displayTicks   = 4;
    localparam int playLimit      = 40;
    localparam int shortRounds    = 8;
    localparam int longRounds     = 16;

    // Compare values at the counter widths
    localparam addressT lastAddress    = addressT'(sequenceLength - 1);
    localparam addressT lastShortRound = addressT'(shortRounds - 1);
    localparam addressT lastLongRound  = addressT'(longRounds - 1);
    localparam timerT   timerHalfLimit = timerT'(playLimit / 2 - 1);
    localparam timerT   timerFullLimit = timerT'(playLimit - 1);
    localparam tickT    displayLast    = tickT'(displayTicks);

    // One-hot colours, one per button and LED
    localparam colorT colorRed    = 4'b0001;
    localparam colorT colorGreen  = 4'b0010;
    localparam colorT colorBlue   = 4'b0100;
    localparam colorT colorYellow = 4'b1000;

    localparam colorT colorSequence [0:sequenceLength-1] = '{
        colorRed,    colorGreen,  colorBlue,   colorRed,
        colorYellow, colorGreen,  colorYellow, colorBlue,
        colorGreen,  colorRed,    colorBlue,   colorYellow,
        colorRed,    colorBlue,   colorGreen,  colorYellow
    };

    // ------------------------------
    // Control unit types
    // ------------------------------
    typedef enum logic [3:0] {
        idle       = 4'h0,
        setup      = 4'h1,
        roundStart = 4'h2,
        showLoad   = 4'h3,
        showWait   = 4'h4,
        showNext   = 4'h5,
        playStart  = 4'h6,
        playWait   = 4'h7,
        capture    = 4'h8,
        compare    = 4'h9,
        gameWon    = 4'hA,
        nextPlay   = 4'hB,
        nextRound  = 4'hC,
        gameLost   = 4'hE,
        timedOut   = 4'hF
    } gameStateT;

    typedef struct packed {
        logic clearAddress;
        logic countAddress;
        logic clearDisplay;
        logic countDisplay;
        logic clearRound;
        logic countRound;
        logic clearTimer;
        logic countTimer;
        logic storePlay;
        logic clearPlay;
        logic storeLevel;
        logic ledsOn;
    } controlT;

    typedef struct packed {
        logic addressEnd;
        logic displayEnd;
        logic roundEnd;
        logic roundHalf;
        logic timerEnd;
        logic timerHalf;
        logic addressIsRound;
        logic playCorrect;
        logic levelTime;
        logic levelPlays;
    } statusT;

endpackage

//--- design/memoryGameTop.sv
// Memory game top level
`timescale 1ns/1ns

module memoryGameTop import memoryGamePkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  colorT     buttons,
    input  logic      levelTime,
    input  logic      levelPlays,
    output colorT     leds,
    output logic      playerTurn,
    output logic      won,
    output logic      lost,
    output logic      timeout,
    output logic      ready,
    output gameStateT stateDebug
);

    logic    playMade;
    colorT   playColor;
    controlT control;
    statusT  status;

    // Decode
    playDecoder u_decoder (
        .clock     (clock),
        .reset     (reset),
        .buttons   (buttons),
        .playMade  (playMade),
        .playColor (playColor)
    );

    // Execute
    gameDatapath u_datapath (
        .clock      (clock),
        .reset      (reset),
        .control    (control),
        .playMade   (playMade),
        .playColor  (playColor),
        .levelTime  (levelTime),
        .levelPlays (levelPlays),
        .status     (status),
        .leds       (leds)
    );

    // Result
    gameControl u_control (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .status     (status),
        .playMade   (playMade),
        .control    (control),
        .playerTurn (playerTurn),
        .won        (won),
        .lost       (lost),
        .timeout    (timeout),
        .ready      (ready),
        .stateDebug (stateDebug)
    );

endmodule

//--- design/playDecoder.sv
// Button press decoder
`timescale 1ns/1ns

module playDecoder import memoryGamePkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  colorT buttons,
    output logic  playMade,
    output colorT playColor
);

    colorT previousButtons;
    logic  pressStart;

    // New press only when every button was released before
    assign pressStart = (previousButtons == '0) && (buttons != '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            previousButtons <= '0;
            playMade        <= 1'b0;
        end else begin
            previousButtons <= buttons;
            playMade        <= pressStart;
        end
    end

    // Colour held until the next press starts
    always_ff @(posedge clock) begin
        if (pressStart) begin
            playColor <= buttons;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // A strobe always comes with a colour already in place
    playHasColor : assert property (
        @(posedge clock) disable iff (reset)
        playMade |-> (playColor != '0)
    );

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the memory game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module memoryGameTb -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/VmemoryGameTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "$output" | grep -qx "TEST OK"
exit $?

//--- test/memoryGameTb.sv
// Memory game testbench
`timescale 1ns/1ns

module memoryGameTb import memoryGamePkg::*; ();

    localparam int clockPeriod = 4;
    localparam int numRows     = 8;

    // Outcome as {won, lost, timeout}
    localparam logic [2:0] expectWon     = 3'b100;
    localparam logic [2:0] expectLost    = 3'b010;
    localparam logic [2:0] expectTimeout = 3'b001;
    localparam logic [4:0] noFail        = 5'd31;

    typedef struct packed {
        logic       levelPlays;
        logic       levelTime;
        logic [4:0] failRound;
        logic [4:0] failPosition;
        logic       wrongColor;
        logic [5:0] pressDelay;
        logic [2:0] outcome;
    } scenarioT;

    // Slow presses use pressDelay, wrong colours a rotated one
    localparam scenarioT scenarios [0:numRows-1] = '{
        '{1'b0, 1'b0, noFail, 5'd0,  1'b0, 6'd0,  expectWon},
        '{1'b1, 1'b0, noFail, 5'd0,  1'b0, 6'd0,  expectWon},
        '{1'b0, 1'b0, 5'd3,   5'd2,  1'b1, 6'd0,  expectLost},
        '{1'b0, 1'b0, 5'd2,   5'd0,  1'b0, 6'd25, expectTimeout},
        '{1'b0, 1'b1, 5'd2,   5'd1,  1'b0, 6'd25, expectWon},
        '{1'b1, 1'b1, 5'd5,   5'd3,  1'b0, 6'd45, expectTimeout},
        '{1'b1, 1'b0, 5'd10,  5'd10, 1'b1, 6'd0,  expectLost},
        '{1'b0, 1'b1, 5'd7,   5'd0,  1'b1, 6'd0,  expectLost}
    };

    logic      clock;
    logic      reset;
    logic      start;
    colorT     buttons;
    logic      levelTime;
    logic      levelPlays;
    colorT     leds;
    logic      playerTurn;
    logic      won, lost, timeout, ready;
    gameStateT stateDebug;

    integer seed;
    int     showIndex;
    int     litCycles;
    colorT  lastLeds;

    memoryGameTop u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Worst case cycles for every row plus some slack
    function automatic int watchdogCycles();
        int total;
        int rounds;
        total = 200;
        for (int i = 0; i < numRows; i++) begin
            rounds = scenarios[i].levelPlays ? longRounds : shortRounds;
            total += rounds * (rounds * 12 + playLimit) + 50;
        end
        return total;
    endfunction

    task automatic waitTurnOrEnd();
        do begin
            @(negedge clock);
        end while (!playerTurn && !ready);
    endtask

    task automatic pressButton(input colorT color);
        @(posedge clock);
        buttons <= color;
        repeat (2) @(posedge clock);
        buttons <= '0;
        repeat (2) @(posedge clock);
    endtask

    task automatic startGame(input scenarioT row);
        @(posedge clock);
        start      <= 1'b1;
        levelTime  <= row.levelTime;
        levelPlays <= row.levelPlays;
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        check(stateDebug, setup, "state after start");
        check({ready, won, lost, timeout}, 4'b0000, "outcome cleared by start");
        showIndex = 0;
    endtask

    task automatic playRow(input scenarioT row);
        int    rounds;
        int    delay;
        logic  stopped;
        logic  failing;
        colorT color;
        rounds  = row.levelPlays ? longRounds : shortRounds;
        stopped = 1'b0;
        startGame(row);
        for (int r = 0; r < rounds && !stopped; r++) begin
            for (int p = 0; p <= r && !stopped; p++) begin
                waitTurnOrEnd();
                check(ready, 1'b0, "game ended before the planned play");
                if (p == 0) begin
                    check(showIndex, r + 1, "colours shown before the round");
                    showIndex = 0;
                end
                failing = (r == row.failRound) && (p == row.failPosition);
                delay   = $unsigned($random(seed)) % 8;
                color   = colorSequence[p];
                if (failing && row.wrongColor) begin
                    color = {color[2:0], color[3]};
                end else if (failing) begin
                    delay = row.pressDelay;
                end
                repeat (delay) @(posedge clock);
                pressButton(color);
                stopped = failing && (row.outcome != expectWon);
            end
        end
        waitTurnOrEnd();
        check(ready, 1'b1, "game over flag");
        check({won, lost, timeout}, row.outcome, "game outcome");
        repeat (10) @(negedge clock);
        check({ready, won, lost, timeout}, {1'b1, row.outcome}, "outcome held");
        check(showIndex, 0, "LEDs lit after the game ended");
    endtask

    // ------------------------------
    // LED monitor
    // ------------------------------
    always @(negedge clock) begin
        if (leds != '0) begin
            // A new colour starts after a dark gap
            if (lastLeds == '0) begin
                showIndex = showIndex + 1;
                litCycles = 0;
            end
            litCycles = litCycles + 1;
            check(leds, colorSequence[showIndex - 1], "LED colour in the show");
        end else if (lastLeds != '0) begin
            check(litCycles, displayTicks + 1, "cycles each colour stays lit");
        end
        lastLeds = leds;
    end

    initial begin
        #(watchdogCycles() * clockPeriod);
        $display("Simulation hung: no game result within the time limit");
        $display("TEST FAILED");
        $fatal(1);
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        seed       = 32'hc2a9c9f4;
        lastLeds   = '0;
        showIndex  = 0;
        litCycles  = 0;
        reset      = 1'b1;
        start      = 1'b0;
        buttons    = '0;
        levelTime  = 1'b0;
        levelPlays = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        // Idle until start
        repeat (5) begin
            @(negedge clock);
            check(stateDebug, idle, "state without start");
            check({ready, won, lost, timeout, playerTurn}, 5'b0, "outputs without start");
            check(leds, '0, "LEDs without start");
        end
        for (int i = 0; i < numRows; i++) begin
            playRow(scenarios[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule
